// File: verilog/fetch_config.svh
/* Instruction fetch configuration
   Widths shared by the fetch RTL and its testbench */

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Address and instruction word width
`define FETCH_ADDR_W 32

// mtvec base field, address bits 31 to 7
`define MTVEC_W 25

// Vectored interrupt index
`define IRQ_IDX_W 5

// Responses still to be dropped after a redirect
`define STALE_CNT_W 2

`endif

// File: verilog/fetch_pkg.sv
/* Instruction fetch types
   Enums and packed structs shared by the fetch stage and its testbench */

`include "fetch_config.svh"

package fetch_pkg;

  // Next-PC source from the controller
  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_TRAP_EXC = 4'd4,
    PC_TRAP_IRQ = 4'd5
  } pc_mux_e;

  // Prefetcher bus FSM
  typedef enum logic [1:0] {
    FS_IDLE        = 2'd0,
    FS_WAIT_GNT    = 2'd1,
    FS_WAIT_RVALID = 2'd2
  } fetch_state_e;

  // Major opcodes produced by the expander
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33
  } rv_opcode_e;

  typedef struct packed {
    logic                  pc_set;
    pc_mux_e               pc_mux;
    logic                  kill_if;
    logic                  halt_if;
    logic [`IRQ_IDX_W-1:0] irq_index;
  } ctrl_fetch_t;

  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] boot_addr;
    logic [`FETCH_ADDR_W-1:0] jump_target;
    logic [`FETCH_ADDR_W-1:0] branch_target;
    logic [`FETCH_ADDR_W-1:0] mepc;
    logic [`MTVEC_W-1:0]      mtvec_base;
  } targets_t;

  typedef struct packed {
    logic                     req;
    logic [`FETCH_ADDR_W-1:0] addr;
  } ibus_req_t;

  typedef struct packed {
    logic                     gnt;
    logic                     rvalid;
    logic [`FETCH_ADDR_W-1:0] rdata;
    logic                     err;
  } ibus_resp_t;

  // One item handed from the prefetcher to the stage
  typedef struct packed {
    logic                     valid;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] rdata;
    logic                     err;
  } fetch_item_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic                     instr_valid;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] instr;
    logic [15:0]              compressed_instr;
    logic                     compressed;
    logic                     illegal_c_insn;
    logic                     bus_err;
  } if_id_pipe_t;

endpackage

// File: verilog/pc_select.sv
/* Next fetch address selection
   Picks the redirect target from the controller command and flags mtvec init on boot */

`include "fetch_config.svh"

module pc_select (
  input  fetch_pkg::ctrl_fetch_t    ctrl_i,
  input  fetch_pkg::targets_t       targets_i,
  output logic [`FETCH_ADDR_W-1:0]  branch_addr_o,
  output logic                      csr_mtvec_init_o
);

  import fetch_pkg::*;

  // Raw target before halfword alignment
  logic [`FETCH_ADDR_W-1:0] target;

  //////////////////////////////////////////////////
  // Target multiplexer
  //////////////////////////////////////////////////

  always_comb begin
    // Boot address as fallback
    target = {targets_i.boot_addr[`FETCH_ADDR_W-1:2], 2'b00};
    case (ctrl_i.pc_mux)
      // Boot always starts word aligned
      PC_BOOT: begin
        target = {targets_i.boot_addr[`FETCH_ADDR_W-1:2], 2'b00};
      end
      PC_JUMP: begin
        target = targets_i.jump_target;
      end
      PC_BRANCH: begin
        target = targets_i.branch_target;
      end
      // Return to the saved exception PC
      PC_MRET: begin
        target = targets_i.mepc;
      end
      // All exceptions share the mtvec base
      PC_TRAP_EXC: begin
        target = {targets_i.mtvec_base, {(`FETCH_ADDR_W - `MTVEC_W){1'b0}}};
      end
      // Vectored interrupts, one word per index
      PC_TRAP_IRQ: begin
        target = {targets_i.mtvec_base, ctrl_i.irq_index, 2'b00};
      end
      default: begin
        target = {targets_i.boot_addr[`FETCH_ADDR_W-1:2], 2'b00};
      end
    endcase
  end

  // Fetch addresses are halfword aligned
  assign branch_addr_o = {target[`FETCH_ADDR_W-1:1], 1'b0};

  // CSR file loads mtvec when the core boots
  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

endmodule

// File: verilog/prefetch_unit.sv
/* Instruction prefetcher
   Requests instructions over the bus, drops responses made stale by a redirect
   and holds one fetched item for the IF stage */

`include "fetch_config.svh"

module prefetch_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0]    branch_addr_i,
  input  logic                        fetch_ready_i,
  output fetch_pkg::ibus_req_t        ibus_req_o,
  input  fetch_pkg::ibus_resp_t       ibus_resp_i,
  output fetch_pkg::fetch_item_t      fetch_o,
  output logic                        busy_o,
  output logic                        protocol_err_o
);

  import fetch_pkg::*;

  fetch_state_e              state_q;
  fetch_state_e              state_d;
  // Set by the first redirect, keeps the FSM idle out of reset
  logic                      started_q;
  // Address on the bus, or the next address to request
  logic [`FETCH_ADDR_W-1:0]  req_addr_q;
  logic [`FETCH_ADDR_W-1:0]  req_addr_d;
  // Redirect seen while an ungranted request must stay on the bus
  logic                      redir_pend_q;
  logic                      redir_pend_d;
  logic [`FETCH_ADDR_W-1:0]  redir_addr_q;
  logic [`FETCH_ADDR_W-1:0]  redir_addr_d;
  logic [`STALE_CNT_W-1:0]   stale_cnt_q;
  logic                      stale_inc;
  logic                      stale_dec;
  // One-entry fetch buffer
  logic                      buf_valid_q;
  logic [`FETCH_ADDR_W-1:0]  buf_pc_q;
  logic [`FETCH_ADDR_W-1:0]  buf_rdata_q;
  logic                      buf_err_q;
  logic                      outstanding;
  logic                      accept_resp;
  logic                      buf_load;
  logic                      can_issue;
  logic [2:0]                instr_len;

  //////////////////////////////////////////////////
  // Response handling
  //////////////////////////////////////////////////

  // Live or stale request awaiting its rvalid
  assign outstanding = (state_q == FS_WAIT_RVALID) || (stale_cnt_q != '0);

  // Bus answers in order, so stale responses come first
  assign stale_dec   = ibus_resp_i.rvalid && (stale_cnt_q != '0);
  assign accept_resp = ibus_resp_i.rvalid && (stale_cnt_q == '0) &&
                       (state_q == FS_WAIT_RVALID);

  // A redirect in the same cycle kills the response
  assign buf_load  = accept_resp && !pc_set_i;

  // Only request when the buffer is free by the next edge
  assign can_issue = started_q && (!buf_valid_q || fetch_ready_i);

  // Length from the low opcode bits
  assign instr_len = (ibus_resp_i.rdata[1:0] == 2'b11) ? 3'd4 : 3'd2;

  //////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    req_addr_d   = req_addr_q;
    redir_pend_d = redir_pend_q;
    redir_addr_d = redir_addr_q;
    stale_inc    = 1'b0;
    case (state_q)
      FS_IDLE: begin
        if (pc_set_i) begin
          req_addr_d = branch_addr_i;
          state_d    = FS_WAIT_GNT;
        end else if (can_issue) begin
          state_d = FS_WAIT_GNT;
        end
      end
      FS_WAIT_GNT: begin
        if (ibus_resp_i.gnt) begin
          if (pc_set_i || redir_pend_q) begin
            // Granted request already belongs to the old path
            stale_inc    = 1'b1;
            redir_pend_d = 1'b0;
            req_addr_d   = pc_set_i ? branch_addr_i : redir_addr_q;
          end else begin
            state_d = FS_WAIT_RVALID;
          end
        end else if (pc_set_i) begin
          // Address must hold until gnt, remember the target
          redir_pend_d = 1'b1;
          redir_addr_d = branch_addr_i;
        end
      end
      FS_WAIT_RVALID: begin
        if (pc_set_i) begin
          // Live request goes stale unless it answers right now
          stale_inc  = !accept_resp;
          req_addr_d = branch_addr_i;
          state_d    = FS_WAIT_GNT;
        end else if (accept_resp) begin
          req_addr_d = req_addr_q + instr_len;
          state_d    = FS_IDLE;
        end
      end
      default: begin
        state_d = FS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= FS_IDLE;
      started_q      <= 1'b0;
      redir_pend_q   <= 1'b0;
      stale_cnt_q    <= '0;
      buf_valid_q    <= 1'b0;
      protocol_err_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      redir_pend_q <= redir_pend_d;
      case ({stale_inc, stale_dec})
        2'b10:   stale_cnt_q <= stale_cnt_q + 1'b1;
        2'b01:   stale_cnt_q <= stale_cnt_q - 1'b1;
        default: stale_cnt_q <= stale_cnt_q;
      endcase
      // rvalid with nothing in flight
      protocol_err_o <= ibus_resp_i.rvalid && !outstanding;
      if (pc_set_i) begin
        started_q <= 1'b1;
      end
      // Flush on redirect, free on consume
      if (buf_load) begin
        buf_valid_q <= 1'b1;
      end else if (pc_set_i || fetch_ready_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Addresses and fetched payload
  always_ff @(posedge clk) begin
    req_addr_q   <= req_addr_d;
    redir_addr_q <= redir_addr_d;
    if (buf_load) begin
      buf_pc_q    <= req_addr_q;
      buf_rdata_q <= ibus_resp_i.rdata;
      buf_err_q   <= ibus_resp_i.err;
    end
  end

  assign ibus_req_o.req  = (state_q == FS_WAIT_GNT);
  assign ibus_req_o.addr = req_addr_q;

  assign fetch_o.valid = buf_valid_q;
  assign fetch_o.pc    = buf_pc_q;
  assign fetch_o.rdata = buf_rdata_q;
  assign fetch_o.err   = buf_err_q;

  assign busy_o = (state_q != FS_IDLE) || (stale_cnt_q != '0);

endmodule

// File: verilog/c_expander.sv
/* Compressed instruction expander
   Maps c.li, c.addi, c.mv and c.add to 32-bit form and flags other compressed words */

`include "fetch_config.svh"

module c_expander (
  input  logic [`FETCH_ADDR_W-1:0]  rdata_i,
  output logic [`FETCH_ADDR_W-1:0]  instr_o,
  output logic                      compressed_o,
  output logic                      illegal_o
);

  import fetch_pkg::*;

  // Common compressed fields
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm12;
  logic [2:0]  funct3;

  assign rd     = rdata_i[11:7];
  assign rs2    = rdata_i[6:2];
  assign funct3 = rdata_i[15:13];

  // CI immediate sign extended to 12 bits
  assign imm12 = {{6{rdata_i[12]}}, rdata_i[12], rdata_i[6:2]};

  // Anything but 11 in the low bits is a 16-bit instruction
  assign compressed_o = (rdata_i[1:0] != 2'b11);

  //////////////////////////////////////////////////
  // Expansion
  //////////////////////////////////////////////////

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;
    if (!compressed_o) begin
      // Full-size word passes through
      instr_o = rdata_i;
    end else begin
      case (rdata_i[1:0])
        // Quadrant 1
        2'b01: begin
          case (funct3)
            // c.addi -> addi rd, rd, imm
            3'b000: begin
              instr_o = {imm12, rd, 3'b000, rd, OPC_OP_IMM};
            end
            // c.li -> addi rd, x0, imm
            3'b010: begin
              instr_o = {imm12, 5'd0, 3'b000, rd, OPC_OP_IMM};
            end
            default: begin
              illegal_o = 1'b1;
            end
          endcase
        end
        // Quadrant 2
        2'b10: begin
          // rs2 of zero encodes jr, jalr and ebreak
          if ((funct3 == 3'b100) && (rs2 != 5'd0)) begin
            if (rdata_i[12]) begin
              // c.add -> add rd, rd, rs2
              instr_o = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
            end else begin
              // c.mv -> add rd, x0, rs2
              instr_o = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP};
            end
          end else begin
            illegal_o = 1'b1;
          end
        end
        // Quadrant 0 not supported
        default: begin
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: verilog/if_stage.sv
/* Instruction fetch stage
   Ties next-PC selection, prefetcher and expander together and owns the IF/ID register */

`include "fetch_config.svh"

module if_stage (
  input  logic                        clk,
  input  logic                        rst_n,
  input  fetch_pkg::ctrl_fetch_t      ctrl_i,
  input  fetch_pkg::targets_t         targets_i,
  input  logic                        id_ready_i,
  output fetch_pkg::ibus_req_t        ibus_req_o,
  input  fetch_pkg::ibus_resp_t       ibus_resp_i,
  output fetch_pkg::if_id_pipe_t      if_id_pipe_o,
  output logic                        if_valid_o,
  output logic [`FETCH_ADDR_W-1:0]    pc_if_o,
  output logic                        if_busy_o,
  output logic                        csr_mtvec_init_o,
  output logic                        protocol_err_o
);

  import fetch_pkg::*;

  logic [`FETCH_ADDR_W-1:0] branch_addr;
  logic                     fetch_ready;
  fetch_item_t              fetch_item;
  logic [`FETCH_ADDR_W-1:0] instr_expanded;
  logic                     instr_compressed;
  logic                     illegal_c_insn;

  //////////////////////////////////////////////////
  // Submodules
  //////////////////////////////////////////////////

  pc_select pc_select_i (
    .ctrl_i           ( ctrl_i           ),
    .targets_i        ( targets_i        ),
    .branch_addr_o    ( branch_addr      ),
    .csr_mtvec_init_o ( csr_mtvec_init_o )
  );

  prefetch_unit prefetch_unit_i (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .pc_set_i       ( ctrl_i.pc_set  ),
    .branch_addr_i  ( branch_addr    ),
    .fetch_ready_i  ( fetch_ready    ),
    .ibus_req_o     ( ibus_req_o     ),
    .ibus_resp_i    ( ibus_resp_i    ),
    .fetch_o        ( fetch_item     ),
    .busy_o         ( if_busy_o      ),
    .protocol_err_o ( protocol_err_o )
  );

  c_expander c_expander_i (
    .rdata_i      ( fetch_item.rdata ),
    .instr_o      ( instr_expanded   ),
    .compressed_o ( instr_compressed ),
    .illegal_o    ( illegal_c_insn   )
  );

  // Killed items are dropped, halted ones wait
  assign if_valid_o  = fetch_item.valid && !ctrl_i.kill_if && !ctrl_i.halt_if;
  assign fetch_ready = ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if);
  assign pc_if_o     = fetch_item.pc;

  //////////////////////////////////////////////////
  // IF/ID pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o <= '0;
    end else begin
      if (if_valid_o && id_ready_i) begin
        if_id_pipe_o.instr_valid    <= 1'b1;
        if_id_pipe_o.pc             <= fetch_item.pc;
        if_id_pipe_o.instr          <= instr_expanded;
        if_id_pipe_o.compressed     <= instr_compressed;
        if_id_pipe_o.illegal_c_insn <= illegal_c_insn;
        if_id_pipe_o.bus_err        <= fetch_item.err;
        // Original 16-bit encoding kept for compressed instructions only
        if (instr_compressed) begin
          if_id_pipe_o.compressed_instr <= fetch_item.rdata[15:0];
        end
      end else if (id_ready_i) begin
        // ID took the last one and nothing new follows
        if_id_pipe_o.instr_valid <= 1'b0;
      end
    end
  end

endmodule

// File: tb/if_stage_props.sv
/* Fetch stage properties
   Bus request stability, response ordering and IF/ID hold under back-pressure */

module if_stage_props (
  input logic                    clk,
  input logic                    rst_n,
  input fetch_pkg::ibus_req_t    ibus_req_i,
  input fetch_pkg::ibus_resp_t   ibus_resp_i,
  input fetch_pkg::if_id_pipe_t  if_id_pipe_i,
  input logic                    id_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  // Granted requests still waiting for their rvalid
  logic [2:0] pending_q;

  // Number of failed assertions
  int unsigned fail_count = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_q + (ibus_req_i.req && ibus_resp_i.gnt) - ibus_resp_i.rvalid;
    end
  end

  // Request must hold until the grant
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ibus_req_i.req && !ibus_resp_i.gnt |=> ibus_req_i.req && $stable(ibus_req_i.addr))
    else begin
      fail_count++;
      $error("bus request changed before its grant");
    end

  a_no_orphan_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    ibus_resp_i.rvalid |-> (pending_q != '0))
    else begin
      fail_count++;
      $error("rvalid without an outstanding request");
    end

  // ID stalled, register frozen
  a_pipe_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable(if_id_pipe_i))
    else begin
      fail_count++;
      $error("IF/ID register changed while ID not ready");
    end

endmodule

bind if_stage if_stage_props if_stage_props_i (
  .clk          ( clk          ),
  .rst_n        ( rst_n        ),
  .ibus_req_i   ( ibus_req_o   ),
  .ibus_resp_i  ( ibus_resp_i  ),
  .if_id_pipe_i ( if_id_pipe_o ),
  .id_ready_i   ( id_ready_i   )
);

// File: tb/tb_if_stage.sv
/* Fetch stage testbench
   Memory model with random bus delays, table of redirects, sequence and field checks */

`include "fetch_config.svh"

module tb_if_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  localparam int TIMEOUT_CYC = 200;
  localparam int NUM_TESTS   = 10;

  typedef struct packed {
    pc_mux_e                  mux;
    logic [`IRQ_IDX_W-1:0]    irq;
    targets_t                 tgt;
    logic [`FETCH_ADDR_W-1:0] exp_pc;
    logic [7:0]               count;
    logic                     rand_ready;
    logic                     redir_busy;
  } test_row_t;

  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] instr;
    logic                     compressed;
    logic                     illegal;
  } expect_t;

  logic                     clk;
  logic                     rst_n;
  ctrl_fetch_t              ctrl;
  targets_t                 targets;
  logic                     id_ready;
  ibus_req_t                ibus_req;
  ibus_resp_t               ibus_resp;
  if_id_pipe_t              if_id_pipe;
  logic                     if_valid;
  logic [`FETCH_ADDR_W-1:0] pc_if;
  logic                     if_busy;
  logic                     mtvec_init;
  logic                     protocol_err;

  test_row_t test_table [NUM_TESTS];
  int        errors;
  int        checks;
  int        cur_test;
  logic      aborted;

  if_stage dut (
    .clk              ( clk          ),
    .rst_n            ( rst_n        ),
    .ctrl_i           ( ctrl         ),
    .targets_i        ( targets      ),
    .id_ready_i       ( id_ready     ),
    .ibus_req_o       ( ibus_req     ),
    .ibus_resp_i      ( ibus_resp    ),
    .if_id_pipe_o     ( if_id_pipe   ),
    .if_valid_o       ( if_valid     ),
    .pc_if_o          ( pc_if        ),
    .if_busy_o        ( if_busy      ),
    .csr_mtvec_init_o ( mtvec_init   ),
    .protocol_err_o   ( protocol_err )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Memory contents and reference models
  //////////////////////////////////////////////////

  // Halfword from a hash of the whole address, mixing 16 and 32-bit code
  function automatic logic [15:0] half_at(input logic [`FETCH_ADDR_W-1:0] a);
    logic [31:0] h;
    logic [4:0]  rs2;
    h   = (a ^ 32'h5bd1_e995) * 32'h9e37_79b1;
    h   = h ^ (h >> 13);
    rs2 = h[24:20] | 5'd1;
    // Region 0x4xxxx carries quadrant 0 words, never supported
    if ((a[31:16] == 16'h0004) && (a[3:1] == 3'd0)) begin
      return {h[15:2], 2'b00};
    end
    case (h[30:28])
      3'd0, 3'd1: return {3'b010, h[12], h[11:7], h[6:2], 2'b01};
      3'd2:       return {3'b000, h[12], h[11:7], h[6:2], 2'b01};
      3'd3:       return {4'b1000, h[11:7], rs2, 2'b10};
      3'd4:       return {4'b1001, h[11:7], rs2, 2'b10};
      default:    return {h[15:2], 2'b11};
    endcase
  endfunction

  // Bus error on every access to region 0x5xxxx
  function automatic logic err_at(input logic [`FETCH_ADDR_W-1:0] a);
    return a[31:16] == 16'h0005;
  endfunction

  // RV32C subset: c.li, c.addi, c.mv, c.add
  function automatic expect_t expand_ref(input logic [31:0] w);
    logic [11:0] imm;
    expect_t     r;
    imm          = {{7{w[12]}}, w[6:2]};
    r.instr      = '0;
    r.compressed = (w[1:0] != 2'b11);
    r.illegal    = 1'b0;
    if (!r.compressed) begin
      r.instr = w;
    end else if ((w[1:0] == 2'b01) && (w[15:13] == 3'b010)) begin
      r.instr = {imm, 5'd0, 3'b000, w[11:7], 7'b0010011};
    end else if ((w[1:0] == 2'b01) && (w[15:13] == 3'b000)) begin
      r.instr = {imm, w[11:7], 3'b000, w[11:7], 7'b0010011};
    end else if ((w[1:0] == 2'b10) && (w[15:12] == 4'b1000) && (w[6:2] != 5'd0)) begin
      r.instr = {7'd0, w[6:2], 5'd0, 3'b000, w[11:7], 7'b0110011};
    end else if ((w[1:0] == 2'b10) && (w[15:12] == 4'b1001) && (w[6:2] != 5'd0)) begin
      r.instr = {7'd0, w[6:2], w[11:7], 3'b000, w[11:7], 7'b0110011};
    end else begin
      r.illegal = 1'b1;
    end
    return r;
  endfunction

  // Distinct values in unused target fields catch a wrong select
  function automatic test_row_t make_row(input pc_mux_e mux, input logic [31:0] target,
                                         input logic [4:0] irq, input logic [31:0] exp_pc,
                                         input int count, input logic rand_ready,
                                         input logic redir_busy);
    test_row_t r;
    r.mux            = mux;
    r.irq            = irq;
    r.tgt.boot_addr     = 32'h0000_7000;
    r.tgt.jump_target   = 32'h0000_7100;
    r.tgt.branch_target = 32'h0000_7200;
    r.tgt.mepc          = 32'h0000_7300;
    r.tgt.mtvec_base    = 25'h00_00e8;
    case (mux)
      PC_BOOT:   r.tgt.boot_addr     = target;
      PC_JUMP:   r.tgt.jump_target   = target;
      PC_BRANCH: r.tgt.branch_target = target;
      PC_MRET:   r.tgt.mepc          = target;
      default:   r.tgt.mtvec_base    = target[`MTVEC_W-1:0];
    endcase
    r.exp_pc     = exp_pc;
    r.count      = count[7:0];
    r.rand_ready = rand_ready;
    r.redir_busy = redir_busy;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Bus model and checks
  //////////////////////////////////////////////////

  // Grant after 0..3 cycles of req, in-order rvalid 1..4 cycles after grant
  task automatic serve_bus();
    logic [`FETCH_ADDR_W-1:0] addr_q [$];
    int unsigned              delay_q [$];
    int unsigned              gnt_wait;
    logic [`FETCH_ADDR_W-1:0] a;
    gnt_wait = 0;
    forever begin
      @(posedge clk);
      if (ibus_req.req && ibus_resp.gnt) begin
        addr_q.push_back(ibus_req.addr);
        delay_q.push_back($urandom_range(3, 0));
        gnt_wait = $urandom_range(3, 0);
      end else if (ibus_req.req && (gnt_wait != 0)) begin
        gnt_wait = gnt_wait - 1;
      end
      ibus_resp.gnt    <= (gnt_wait == 0);
      ibus_resp.rvalid <= 1'b0;
      if (delay_q.size() > 0) begin
        if (delay_q[0] == 0) begin
          a = addr_q.pop_front();
          void'(delay_q.pop_front());
          ibus_resp.rvalid <= 1'b1;
          ibus_resp.rdata  <= {half_at(a + 32'd2), half_at(a)};
          ibus_resp.err    <= err_at(a);
        end else begin
          delay_q[0] = delay_q[0] - 1;
        end
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH test %0d %s: got %h expected %h", cur_test, name, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("Test %0d timed out after %0d cycles waiting for %s", cur_test, TIMEOUT_CYC, what);
  endtask

  task automatic run_row(input int t);
    test_row_t                row;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] if_pc;
    logic [31:0]              word;
    expect_t                  ex;
    int                       got;
    int                       cyc;
    int                       errs_before;
    logic                     xfer;
    row         = test_table[t];
    cur_test    = t;
    errs_before = errors;
    // Redirect right as a request is granted, so a response is in flight
    xfer = 1'b0;
    cyc  = 0;
    if (row.redir_busy) begin
      while (!xfer && (cyc < TIMEOUT_CYC)) begin
        @(posedge clk);
        xfer = ibus_req.req && ibus_resp.gnt;
        // A held item must drain before the next request goes out
        id_ready <= 1'b1;
        cyc++;
      end
      if (!xfer) begin
        note_timeout("a bus grant");
      end
    end else begin
      @(posedge clk);
    end
    if (!aborted) begin
      ctrl.pc_set    <= 1'b1;
      ctrl.kill_if   <= 1'b1;
      ctrl.pc_mux    <= row.mux;
      ctrl.irq_index <= row.irq;
      targets        <= row.tgt;
      @(negedge clk);
      check_value("csr_mtvec_init_o", mtvec_init, row.mux == PC_BOOT);
      @(posedge clk);
      ctrl.pc_set  <= 1'b0;
      ctrl.kill_if <= 1'b0;
      @(negedge clk);
      check_value("csr_mtvec_init_o", mtvec_init, 32'd0);
      // Redirect starts a fetch
      check_value("if_busy_o", if_busy, 32'd1);
    end
    // Collect the instructions handed to ID
    pc  = row.exp_pc;
    got = 0;
    cyc = 0;
    while (!aborted && (got < row.count) && (cyc < TIMEOUT_CYC)) begin
      @(posedge clk);
      xfer  = if_valid && id_ready;
      if_pc = pc_if;
      id_ready <= row.rand_ready ? (($urandom & 32'd1) == 32'd1) : 1'b1;
      check_value("protocol_err_o", protocol_err, 32'd0);
      cyc++;
      if (xfer) begin
        @(negedge clk);
        word = {half_at(pc + 32'd2), half_at(pc)};
        ex   = expand_ref(word);
        check_value("pc_if_o", if_pc, pc);
        check_value("instr_valid", if_id_pipe.instr_valid, 32'd1);
        check_value("pc", if_id_pipe.pc, pc);
        check_value("instr", if_id_pipe.instr, ex.instr);
        check_value("compressed", if_id_pipe.compressed, ex.compressed);
        check_value("illegal_c_insn", if_id_pipe.illegal_c_insn, ex.illegal);
        check_value("bus_err", if_id_pipe.bus_err, err_at(pc));
        if (ex.compressed) begin
          check_value("compressed_instr", if_id_pipe.compressed_instr, word[15:0]);
        end
        pc  = pc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
        got++;
        cyc = 0;
      end
    end
    if (!aborted && (got < row.count)) begin
      note_timeout("the next instruction");
    end
    $display("test %0d %s to %h: %0d of %0d instructions, %0d errors",
             t, row.mux.name(), row.exp_pc, got, row.count, errors - errs_before);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h78ce_e780));
    rst_n     = 1'b0;
    ctrl      = '0;
    targets   = '0;
    id_ready  = 1'b1;
    ibus_resp = '0;
    errors    = 0;
    checks    = 0;
    cur_test  = 0;
    aborted   = 1'b0;
    // Boot, redirects in flight, traps, illegal and bus error regions, back-pressure
    test_table[0] = make_row(PC_BOOT,     32'h0000_1002, 5'd0,  32'h0000_1000, 24, 1'b0, 1'b0);
    test_table[1] = make_row(PC_JUMP,     32'h0000_2346, 5'd0,  32'h0000_2346, 12, 1'b0, 1'b1);
    test_table[2] = make_row(PC_BRANCH,   32'h0000_3101, 5'd0,  32'h0000_3100, 12, 1'b0, 1'b1);
    test_table[3] = make_row(PC_MRET,     32'h0000_1800, 5'd0,  32'h0000_1800, 8,  1'b0, 1'b0);
    test_table[4] = make_row(PC_TRAP_EXC, 32'h0000_0040, 5'd0,  32'h0000_2000, 8,  1'b0, 1'b1);
    test_table[5] = make_row(PC_TRAP_IRQ, 32'h0000_0040, 5'd11, 32'h0000_202c, 8,  1'b0, 1'b0);
    test_table[6] = make_row(PC_JUMP,     32'h0004_0000, 5'd0,  32'h0004_0000, 20, 1'b0, 1'b1);
    test_table[7] = make_row(PC_BRANCH,   32'h0005_0010, 5'd0,  32'h0005_0010, 6,  1'b0, 1'b0);
    test_table[8] = make_row(PC_BOOT,     32'h0000_1000, 5'd0,  32'h0000_1000, 24, 1'b1, 1'b1);
    test_table[9] = make_row(PC_JUMP,     32'h0000_2346, 5'd0,  32'h0000_2346, 16, 1'b1, 1'b1);
    fork
      serve_bus();
    join_none
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    // Idle until the first redirect
    repeat (4) @(negedge clk);
    check_value("req", ibus_req.req, 32'd0);
    check_value("if_valid_o", if_valid, 32'd0);
    check_value("instr_valid", if_id_pipe.instr_valid, 32'd0);
    check_value("protocol_err_o", protocol_err, 32'd0);
    check_value("if_busy_o", if_busy, 32'd0);
    for (int t = 0; (t < NUM_TESTS) && !aborted; t++) begin
      run_row(t);
    end
    // Bound assertion failures count as errors
    errors = errors + int'(dut.if_stage_props_i.fail_count);
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pc_select.sv
verilog/prefetch_unit.sv
verilog/c_expander.sv
verilog/if_stage.sv
tb/if_stage_props.sv
tb/tb_if_stage.sv

// File: Bender.yml
package:
  name: rv_fetch

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/pc_select.sv
      - verilog/prefetch_unit.sv
      - verilog/c_expander.sv
      - verilog/if_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/if_stage_props.sv
      - tb/tb_if_stage.sv
